// ==== sources.f ====
+incdir+hw
hw/instr_pkg.sv
hw/issue_pkg.sv
hw/issue_queue.sv
hw/pair_check.sv
hw/reg_file.sv
hw/operand_select.sv
hw/issue_stage_top.sv
tb/issue_stage_checker.sv
tb/issue_stage_tb.sv

// ==== Makefile ====
TOP  := issue_stage_tb
SRCS := $(shell grep -v '^+' sources.f) hw/issue_settings.svh

.PHONY: run clean

obj_dir/V$(TOP): sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) \
		--Mdir obj_dir -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// ==== tb/issue_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_stage_tb;
    localparam int RESET_CYCLES = 3;

    typedef struct {
        instr_pkg::decoded_instr_t i1, i0, e1, e0;
        logic stall, flush, eslot;
        logic [3:0] rdy, byp;
        logic [31:0] bdata;
        int cycles;
    } row_t;

    logic clk, rst_n, stall, stall_decode, flush, wb_we, overflow;
    instr_pkg::decoded_instr_t dec_instr_1, dec_instr_0;
    logic src_ready_1a, src_ready_1b, src_ready_0a, src_ready_0b;
    logic src_bypass_1a, src_bypass_1b, src_bypass_0a, src_bypass_0b;
    logic [`DATA_W-1:0] src_data_1a, src_data_1b, src_data_0a, src_data_0b, wb_data;
    logic [`REG_ADDR_W-1:0] wb_addr, read_addr_1a, read_addr_1b, read_addr_0a, read_addr_0b;
    issue_pkg::issued_instr_t iss_instr_1, iss_instr_0;

    logic [31:0] model [32];
    logic [31:0] lcg_state = 32'd41520;
    instr_pkg::decoded_instr_t prog [26];
    row_t rows [$];
    int errors = 0;
    int cycle_count = 0;
    int limit = 100000;

    issue_stage_top issue_stage_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // tb-side decode of the operation classes
    function automatic instr_pkg::decoded_instr_t mk(input int idx, input instr_pkg::opcode_e op,
                                                     input logic [4:0] a, b, d);
        instr_pkg::decoded_instr_t x;
        x = '0;
        x.valid = 1'b1;
        x.pc = 32'h100 + 32'(4 * idx);
        x.raw_instr = x.pc ^ 32'h0c00_0000;
        x.op = op;
        x.ra1 = a;
        x.ra2 = b;
        x.rdst = d;
        x.regwrite = d != 5'd0;
        if (op == instr_pkg::OP_MULT || op == instr_pkg::OP_MULTU ||
            op == instr_pkg::OP_DIV || op == instr_pkg::OP_DIVU) begin
            x.hiwrite = 1'b1;
            x.lowrite = 1'b1;
        end
        x.hiwrite  = x.hiwrite || op == instr_pkg::OP_MTHI;
        x.lowrite  = x.lowrite || op == instr_pkg::OP_MTLO;
        x.hitoreg  = op == instr_pkg::OP_MFHI;
        x.lotoreg  = op == instr_pkg::OP_MFLO;
        x.cp0write = op == instr_pkg::OP_MTC0;
        x.cp0toreg = op == instr_pkg::OP_MFC0;
        x.branch   = op == instr_pkg::OP_BRANCH;
        x.jump     = op == instr_pkg::OP_JUMP;
        if (op == instr_pkg::OP_SYSCALL)
            x.cp0_kind = instr_pkg::CP0_EXCEPTION;
        if (op == instr_pkg::OP_ERET)
            x.cp0_kind = instr_pkg::CP0_ERET;
        return x;
    endfunction

    function automatic row_t new_row(input instr_pkg::decoded_instr_t i1, i0, e1, e0,
                                     input logic [3:0] rdy, input logic eslot, input int cycles);
        row_t r;
        r.i1 = i1;
        r.i0 = i0;
        r.e1 = e1;
        r.e0 = e0;
        r.rdy = rdy;
        r.eslot = eslot;
        r.cycles = cycles;
        r.stall = 1'b0;
        r.flush = 1'b0;
        r.byp = 4'h0;
        r.bdata = 32'h0;
        return r;
    endfunction

    task automatic check(input logic [31:0] act, exp, input string msg);
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, msg, act, exp);
        end
    endtask

    // bit 3..0 map to sources 1a 1b 0a 0b
    task automatic apply_sources(input logic [3:0] rdy, byp, input logic [31:0] bdata);
        {src_ready_1a, src_ready_1b, src_ready_0a, src_ready_0b} = rdy;
        {src_bypass_1a, src_bypass_1b, src_bypass_0a, src_bypass_0b} = byp;
        src_data_1a = bdata;
        src_data_1b = bdata + 32'd1;
        src_data_0a = bdata + 32'd2;
        src_data_0b = bdata + 32'd3;
    endtask

    task automatic check_slot(input issue_pkg::issued_instr_t act,
                              input instr_pkg::decoded_instr_t exp,
                              input logic [4:0] addr_a, addr_b,
                              input logic byp_a, byp_b, input logic [31:0] da, db,
                              input string name);
        logic [31:0] ea, eb;
        ea = byp_a ? da : model[exp.ra1];
        eb = byp_b ? db : model[exp.ra2];
        check(32'(act.valid), 32'(exp.valid), {name, " valid"});
        check(act.pc, exp.pc, {name, " pc"});
        if (exp.valid) begin
            check(32'(addr_a), 32'(exp.ra1), {name, " read addr a"});
            check(32'(addr_b), 32'(exp.ra2), {name, " read addr b"});
            check(32'(act.rdst), 32'(exp.rdst), {name, " rdst"});
            check(act.rd1, ea, {name, " rd1"});
            check(act.rd2, eb, {name, " rd2"});
        end
    endtask

    initial begin
        row_t r;
        instr_pkg::decoded_instr_t z;
        z = '0;
        rst_n = 1'b0;
        stall = 1'b0;
        stall_decode = 1'b0;
        flush = 1'b0;
        dec_instr_1 = '0;
        dec_instr_0 = '0;
        wb_we = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        apply_sources(4'hF, 4'h0, 32'h0);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // preload registers through the writeback port
        model[0] = 32'h0;
        for (int k = 1; k < 32; k++) begin
            wb_we = 1'b1;
            wb_addr = 5'(k);
            wb_data = lcg_next();
            model[k] = wb_data;
            @(negedge clk);
        end
        wb_we = 1'b0;

        prog[0]  = mk(0, instr_pkg::OP_ALU, 1, 2, 3);
        prog[1]  = mk(1, instr_pkg::OP_ALU, 4, 5, 6);
        prog[2]  = mk(2, instr_pkg::OP_ALU, 1, 2, 7);
        prog[3]  = mk(3, instr_pkg::OP_ALU, 7, 3, 8);
        prog[4]  = mk(4, instr_pkg::OP_MULT, 1, 2, 0);
        prog[5]  = mk(5, instr_pkg::OP_DIV, 3, 4, 0);
        prog[6]  = mk(6, instr_pkg::OP_MTHI, 1, 0, 0);
        prog[7]  = mk(7, instr_pkg::OP_MFHI, 0, 0, 9);
        prog[8]  = mk(8, instr_pkg::OP_MTC0, 0, 5, 0);
        prog[9]  = mk(9, instr_pkg::OP_MFC0, 0, 0, 10);
        prog[10] = mk(10, instr_pkg::OP_ERET, 0, 0, 0);
        prog[11] = mk(11, instr_pkg::OP_ALU, 1, 2, 11);
        prog[12] = mk(12, instr_pkg::OP_BRANCH, 1, 2, 0);
        prog[13] = mk(13, instr_pkg::OP_ALU, 3, 4, 12);
        prog[14] = mk(14, instr_pkg::OP_BRANCH, 5, 6, 0);
        prog[15] = mk(15, instr_pkg::OP_ALU, 7, 8, 13);
        prog[16] = mk(16, instr_pkg::OP_ALU, 9, 10, 14);
        prog[17] = mk(17, instr_pkg::OP_ALU, 11, 12, 15);
        prog[18] = mk(18, instr_pkg::OP_ALU, 13, 14, 16);
        prog[19] = mk(19, instr_pkg::OP_ALU, 15, 12, 17);
        prog[20] = mk(20, instr_pkg::OP_ALU, 1, 1, 18);
        prog[21] = mk(21, instr_pkg::OP_ALU, 2, 2, 19);
        prog[22] = mk(22, instr_pkg::OP_ALU, 3, 5, 20);
        prog[23] = mk(23, instr_pkg::OP_ALU, 6, 7, 21);
        prog[24] = mk(24, instr_pkg::OP_ALU, 8, 9, 22);
        prog[25] = mk(25, instr_pkg::OP_ALU, 10, 11, 23);

        // independent pair, then pairs that split into two cycles
        rows.push_back(new_row(prog[0], prog[1], prog[0], prog[1], 4'hF, 1'b0, 1));
        for (int p = 2; p <= 10; p += 2) begin
            rows.push_back(new_row(prog[p], prog[p+1], prog[p], z, 4'hF, 1'b0, 1));
            rows.push_back(new_row(z, z, prog[p+1], z, 4'hF, 1'b0, 1));
        end
        // branch with its delay slot, ready and then waiting on a source
        rows.push_back(new_row(prog[12], prog[13], prog[12], prog[13], 4'hF, 1'b1, 1));
        rows.push_back(new_row(prog[14], prog[15], z, z, 4'b1101, 1'b0, 1));
        rows.push_back(new_row(z, z, prog[14], prog[15], 4'hF, 1'b1, 1));
        r = new_row(prog[16], prog[17], prog[16], prog[17], 4'hF, 1'b0, 1);
        r.byp = 4'b1010;
        r.bdata = 32'hb000_0000;
        rows.push_back(r);
        // held stall
        rows.push_back(new_row(prog[18], prog[19], z, z, 4'h0, 1'b0, 1));
        r = new_row(prog[20], prog[21], prog[18], prog[19], 4'hF, 1'b0, 1);
        r.stall = 1'b1;
        rows.push_back(r);
        r = new_row(z, z, prog[18], prog[19], 4'hF, 1'b0, 2);
        r.stall = 1'b1;
        rows.push_back(r);
        rows.push_back(new_row(z, z, z, z, 4'hF, 1'b0, 1));
        // flush drops queued entries
        rows.push_back(new_row(prog[22], prog[23], z, z, 4'h0, 1'b0, 1));
        r = new_row(z, z, z, z, 4'hF, 1'b0, 1);
        r.flush = 1'b1;
        rows.push_back(r);
        rows.push_back(new_row(prog[24], prog[25], prog[24], prog[25], 4'hF, 1'b0, 1));

        // two extra rows' worth for the overflow phase
        limit = 20 * (rows.size() + 2) + RESET_CYCLES + 40;

        dec_instr_1 = rows[0].i1;
        dec_instr_0 = rows[0].i0;
        stall = rows[0].stall;
        flush = rows[0].flush;
        foreach (rows[n]) begin
            r = rows[n];
            // sources of the previous row hold through the first edge
            for (int k = 0; k < r.cycles; k++) begin
                @(posedge clk);
                @(negedge clk);
                dec_instr_1 = '0;
                dec_instr_0 = '0;
                flush = 1'b0;
                apply_sources(r.rdy, r.byp, r.bdata);
            end
            // next row's instructions are only written at the coming edge
            if (n + 1 < rows.size()) begin
                dec_instr_1 = rows[n+1].i1;
                dec_instr_0 = rows[n+1].i0;
                stall = rows[n+1].stall;
                flush = rows[n+1].flush;
            end
            #1;
            check_slot(iss_instr_1, r.e1, read_addr_1a, read_addr_1b, r.byp[3], r.byp[2],
                       r.bdata, r.bdata + 32'd1, $sformatf("row %0d slot 1", n));
            check_slot(iss_instr_0, r.e0, read_addr_0a, read_addr_0b, r.byp[1], r.byp[0],
                       r.bdata + 32'd2, r.bdata + 32'd3, $sformatf("row %0d slot 0", n));
            check(32'(iss_instr_0.is_slot), 32'(r.eslot), $sformatf("row %0d is_slot", n));
            check(32'(overflow), 32'd0, $sformatf("row %0d overflow", n));
        end

        // overflow, fill both banks with nothing issuing
        @(negedge clk);
        flush = 1'b1;
        @(posedge clk);
        @(negedge clk);
        flush = 1'b0;
        apply_sources(4'h0, 4'h0, 32'h0);
        for (int k = 0; k < 15; k++) begin
            dec_instr_1 = mk(64 + 2 * k, instr_pkg::OP_ALU, 1, 2, 3);
            dec_instr_0 = mk(65 + 2 * k, instr_pkg::OP_ALU, 4, 5, 6);
            @(posedge clk);
            @(negedge clk);
            check(32'(overflow), 32'(k == 14), $sformatf("fill %0d overflow", k));
        end
        dec_instr_1 = '0;
        dec_instr_0 = '0;
        // decode still active, heads hold under stall
        stall = 1'b1;
        stall_decode = 1'b1;
        apply_sources(4'hF, 4'h0, 32'h0);
        @(posedge clk);
        @(negedge clk);
        check(32'(overflow), 32'd1, "overflow held with decode active");
        check(iss_instr_1.pc, 32'h200, "drain first pc");
        // drain one pair under stall through the overflow path
        stall_decode = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check(32'(overflow), 32'd0, "overflow after drain");
        check(iss_instr_1.pc, 32'h208, "held pc after drain");
        stall = 1'b0;
        while (iss_instr_1.valid)
            @(negedge clk);
        check(32'(overflow), 32'd0, "overflow when empty");

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/issue_stage_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     flush,
    input logic                     overflow,
    input issue_pkg::issued_instr_t iss_instr_1,
    input issue_pkg::issued_instr_t iss_instr_0
);
    // younger slot only rides along with the older one
    a_young_needs_old: assert property (@(posedge clk) disable iff (!rst_n)
        iss_instr_0.valid |-> iss_instr_1.valid)
        else $error("young slot issued without old slot");

    // queue is empty right after a flush
    a_flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        $past(flush) |-> !iss_instr_1.valid && !iss_instr_0.valid)
        else $error("instruction issued in the cycle after flush");

    // pointers cleared by reset
    a_no_overflow_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !overflow)
        else $error("overflow high after reset");

    // control never sits in the young slot
    a_young_not_control: assert property (@(posedge clk) disable iff (!rst_n)
        iss_instr_0.valid |-> !(iss_instr_0.branch || iss_instr_0.jump))
        else $error("branch or jump issued in young slot");

endmodule

bind issue_stage_top issue_stage_checker issue_stage_checker_inst (
    .clk(clk), .rst_n(rst_n), .flush(flush), .overflow(overflow),
    .iss_instr_1(iss_instr_1), .iss_instr_0(iss_instr_0)
);

`default_nettype wire

// ==== hw/issue_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_stage_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  instr_pkg::decoded_instr_t dec_instr_1,
    input  instr_pkg::decoded_instr_t dec_instr_0,
    input  logic                      stall,
    input  logic                      stall_decode,
    input  logic                      flush,
    input  logic                      src_ready_1a,
    input  logic                      src_ready_1b,
    input  logic                      src_ready_0a,
    input  logic                      src_ready_0b,
    input  logic                      src_bypass_1a,
    input  logic                      src_bypass_1b,
    input  logic                      src_bypass_0a,
    input  logic                      src_bypass_0b,
    input  logic [`DATA_W-1:0]        src_data_1a,
    input  logic [`DATA_W-1:0]        src_data_1b,
    input  logic [`DATA_W-1:0]        src_data_0a,
    input  logic [`DATA_W-1:0]        src_data_0b,
    input  logic                      wb_we,
    input  logic [`REG_ADDR_W-1:0]    wb_addr,
    input  logic [`DATA_W-1:0]        wb_data,
    output issue_pkg::issued_instr_t  iss_instr_1,
    output issue_pkg::issued_instr_t  iss_instr_0,
    output logic [`REG_ADDR_W-1:0]    read_addr_1a,
    output logic [`REG_ADDR_W-1:0]    read_addr_1b,
    output logic [`REG_ADDR_W-1:0]    read_addr_0a,
    output logic [`REG_ADDR_W-1:0]    read_addr_0b,
    output logic                      overflow
);
    instr_pkg::decoded_instr_t cand_old, cand_young;
    logic issue_old, issue_young, slot_mark;
    logic [`DATA_W-1:0] rf_data_1a, rf_data_1b, rf_data_0a, rf_data_0b;

    // slot 1 is the older candidate, slot 0 the younger
    assign read_addr_1a = cand_old.ra1;
    assign read_addr_1b = cand_old.ra2;
    assign read_addr_0a = cand_young.ra1;
    assign read_addr_0b = cand_young.ra2;

    issue_queue issue_queue_inst (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .stall(stall), .stall_decode(stall_decode),
        .dec_instr_1(dec_instr_1), .dec_instr_0(dec_instr_0),
        .issue_old(issue_old), .issue_young(issue_young),
        .cand_old(cand_old), .cand_young(cand_young),
        .overflow(overflow)
    );

    pair_check pair_check_inst (
        .cand_old(cand_old), .cand_young(cand_young),
        .ready_old_a(src_ready_1a), .ready_old_b(src_ready_1b),
        .ready_young_a(src_ready_0a), .ready_young_b(src_ready_0b),
        .issue_old(issue_old), .issue_young(issue_young), .slot_mark(slot_mark)
    );

    reg_file reg_file_inst (
        .clk(clk), .rst_n(rst_n),
        .we(wb_we), .waddr(wb_addr), .wdata(wb_data),
        .raddr_1a(read_addr_1a), .raddr_1b(read_addr_1b),
        .raddr_0a(read_addr_0a), .raddr_0b(read_addr_0b),
        .rdata_1a(rf_data_1a), .rdata_1b(rf_data_1b),
        .rdata_0a(rf_data_0a), .rdata_0b(rf_data_0b)
    );

    operand_select operand_select_inst (
        .cand_old(cand_old), .cand_young(cand_young),
        .issue_old(issue_old), .issue_young(issue_young), .slot_mark(slot_mark),
        .rf_data_1a(rf_data_1a), .rf_data_1b(rf_data_1b),
        .rf_data_0a(rf_data_0a), .rf_data_0b(rf_data_0b),
        .bypass_1a(src_bypass_1a), .bypass_1b(src_bypass_1b),
        .bypass_0a(src_bypass_0a), .bypass_0b(src_bypass_0b),
        .bypass_data_1a(src_data_1a), .bypass_data_1b(src_data_1b),
        .bypass_data_0a(src_data_0a), .bypass_data_0b(src_data_0b),
        .iss_instr_1(iss_instr_1), .iss_instr_0(iss_instr_0)
    );

endmodule

`default_nettype wire

// ==== hw/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module operand_select (
    input  instr_pkg::decoded_instr_t cand_old,
    input  instr_pkg::decoded_instr_t cand_young,
    input  logic                      issue_old,
    input  logic                      issue_young,
    input  logic                      slot_mark,
    input  logic [`DATA_W-1:0]        rf_data_1a,
    input  logic [`DATA_W-1:0]        rf_data_1b,
    input  logic [`DATA_W-1:0]        rf_data_0a,
    input  logic [`DATA_W-1:0]        rf_data_0b,
    input  logic                      bypass_1a,
    input  logic                      bypass_1b,
    input  logic                      bypass_0a,
    input  logic                      bypass_0b,
    input  logic [`DATA_W-1:0]        bypass_data_1a,
    input  logic [`DATA_W-1:0]        bypass_data_1b,
    input  logic [`DATA_W-1:0]        bypass_data_0a,
    input  logic [`DATA_W-1:0]        bypass_data_0b,
    output issue_pkg::issued_instr_t  iss_instr_1,
    output issue_pkg::issued_instr_t  iss_instr_0
);
    logic [`DATA_W-1:0] opnd_1a, opnd_1b, opnd_0a, opnd_0b;

    // copy decoded fields, attach operand values
    function automatic issue_pkg::issued_instr_t build_issued(
        input instr_pkg::decoded_instr_t cand,
        input logic [`DATA_W-1:0]        data_a,
        input logic [`DATA_W-1:0]        data_b
    );
        issue_pkg::issued_instr_t rec;
        rec           = '0;
        rec.valid     = cand.valid;
        rec.pc        = cand.pc;
        rec.raw_instr = cand.raw_instr;
        rec.op        = cand.op;
        rec.rdst      = cand.rdst;
        rec.imm       = cand.imm;
        rec.regwrite  = cand.regwrite;
        rec.branch    = cand.branch;
        rec.jump      = cand.jump;
        rec.hiwrite   = cand.hiwrite;
        rec.lowrite   = cand.lowrite;
        rec.hitoreg   = cand.hitoreg;
        rec.lotoreg   = cand.lotoreg;
        rec.cp0write  = cand.cp0write;
        rec.cp0toreg  = cand.cp0toreg;
        rec.cp0_kind  = cand.cp0_kind;
        rec.cp0_addr  = cand.cp0_addr;
        rec.rd1       = data_a;
        rec.rd2       = data_b;
        return rec;
    endfunction

    // bypass wins over the register file, per source
    assign opnd_1a = bypass_1a ? bypass_data_1a : rf_data_1a;
    assign opnd_1b = bypass_1b ? bypass_data_1b : rf_data_1b;
    assign opnd_0a = bypass_0a ? bypass_data_0a : rf_data_0a;
    assign opnd_0b = bypass_0b ? bypass_data_0b : rf_data_0b;

    always_comb begin
        iss_instr_1 = '0;
        iss_instr_0 = '0;
        if (issue_old)
            iss_instr_1 = build_issued(cand_old, opnd_1a, opnd_1b);
        if (issue_young) begin
            iss_instr_0         = build_issued(cand_young, opnd_0a, opnd_0b);
            iss_instr_0.is_slot = slot_mark;
        end
    end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`DATA_W-1:0]     wdata,
    input  logic [`REG_ADDR_W-1:0] raddr_1a,
    input  logic [`REG_ADDR_W-1:0] raddr_1b,
    input  logic [`REG_ADDR_W-1:0] raddr_0a,
    input  logic [`REG_ADDR_W-1:0] raddr_0b,
    output logic [`DATA_W-1:0]     rdata_1a,
    output logic [`DATA_W-1:0]     rdata_1b,
    output logic [`DATA_W-1:0]     rdata_0a,
    output logic [`DATA_W-1:0]     rdata_0b
);
    logic [`DATA_W-1:0] regs [`REG_COUNT];

    // $zero is hardwired
    function automatic logic [`DATA_W-1:0] read_reg(input logic [`REG_ADDR_W-1:0] addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads, two per slot
    assign rdata_1a = read_reg(raddr_1a);
    assign rdata_1b = read_reg(raddr_1b);
    assign rdata_0a = read_reg(raddr_0a);
    assign rdata_0b = read_reg(raddr_0b);

endmodule

`default_nettype wire

// ==== hw/pair_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_check (
    input  instr_pkg::decoded_instr_t cand_old,
    input  instr_pkg::decoded_instr_t cand_young,
    input  logic                      ready_old_a,
    input  logic                      ready_old_b,
    input  logic                      ready_young_a,
    input  logic                      ready_young_b,
    output logic                      issue_old,
    output logic                      issue_young,
    output logic                      slot_mark
);
    logic old_ctl;
    logic old_ready, young_ready;
    logic raw_hazard;
    logic muldiv_clash;
    logic cp0_clash;
    logic hilo_clash;
    logic old_traps;
    logic blocked;

    assign old_ctl = issue_pkg::is_control(cand_old);

    // both sources available
    assign old_ready   = cand_old.valid && ready_old_a && ready_old_b;
    assign young_ready = cand_young.valid && ready_young_a && ready_young_b;

    // a branch or jump waits for its delay slot
    assign issue_old = old_ready && (!old_ctl || young_ready);

    // read after write inside the pair
    // delay slot is exempt, it reads the pre-branch value
    assign raw_hazard = cand_old.regwrite && !old_ctl &&
                        (cand_old.rdst == cand_young.ra1 ||
                         cand_old.rdst == cand_young.ra2);

    // single multiply/divide unit
    assign muldiv_clash = issue_pkg::is_muldiv(cand_old.op) &&
                          issue_pkg::is_muldiv(cand_young.op);

    // cp0 address may match, so keep cp0 accesses apart
    // read before write is the one safe order
    assign cp0_clash = (cand_old.cp0write && cand_young.cp0write) ||
                       (cand_old.cp0write && cand_young.cp0toreg) ||
                       (cand_old.cp0toreg && cand_young.cp0toreg);

    // hi/lo written then read
    assign hilo_clash = (cand_old.lowrite && cand_young.lotoreg) ||
                        (cand_old.hiwrite && cand_young.hitoreg);

    // younger must not run past a trap or eret
    assign old_traps = cand_old.cp0_kind == instr_pkg::CP0_EXCEPTION ||
                       cand_old.cp0_kind == instr_pkg::CP0_ERET;

    assign blocked = raw_hazard || muldiv_clash || cp0_clash || hilo_clash ||
                     old_traps || issue_pkg::is_control(cand_young);

    assign issue_young = young_ready && issue_old && !blocked;

    // older control issued, younger rides in its delay slot
    assign slot_mark = issue_old && old_ctl;

endmodule

`default_nettype wire

// ==== hw/issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_queue (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      stall,
    input  logic                      stall_decode,
    input  instr_pkg::decoded_instr_t dec_instr_1,
    input  instr_pkg::decoded_instr_t dec_instr_0,
    input  logic                      issue_old,
    input  logic                      issue_young,
    output instr_pkg::decoded_instr_t cand_old,
    output instr_pkg::decoded_instr_t cand_young,
    output logic                      overflow
);
    localparam int DEPTH = `ISSUE_QUEUE_DEPTH;

    typedef logic [`ISSUE_INDEX_W-1:0] index_t;

    instr_pkg::decoded_instr_t even_bank [DEPTH];
    instr_pkg::decoded_instr_t odd_bank  [DEPTH];

    index_t head_even, head_odd;
    index_t tail_even, tail_odd;

    logic odd_first, tails_equal;
    logic even_empty, odd_empty;
    logic wr_even, wr_odd;
    instr_pkg::decoded_instr_t wdata_even, wdata_odd;
    logic advance, pop_even, pop_odd;

    // pointers walk downward and wrap 0 -> top
    function automatic index_t step(input index_t idx);
        return (idx == '0) ? index_t'(DEPTH - 1) : idx - 1'b1;
    endfunction

    // equal heads mean the odd bank holds the oldest entry
    assign odd_first   = head_odd == head_even;
    assign tails_equal = tail_odd == tail_even;
    assign even_empty  = head_even == tail_even;
    assign odd_empty   = head_odd == tail_odd;

    // one more write in a bank would collide with its head
    assign overflow = (step(tail_odd) == head_odd) || (step(tail_even) == head_even);

    // candidates, zero when the bank is empty
    always_comb begin
        cand_old   = '0;
        cand_young = '0;
        if (odd_first && !odd_empty) begin
            cand_old = odd_bank[head_odd];
        end else if (!odd_first && !even_empty) begin
            cand_old = even_bank[head_even];
        end
        if (odd_first && !even_empty) begin
            cand_young = even_bank[head_even];
        end else if (!odd_first && !odd_empty) begin
            cand_young = odd_bank[head_odd];
        end
    end

    // bank steering, older goes odd when tails line up
    always_comb begin
        if (tails_equal) begin
            wr_odd     = dec_instr_1.valid;
            wdata_odd  = dec_instr_1;
            wr_even    = dec_instr_0.valid;
            wdata_even = dec_instr_0;
        end else begin
            wr_even    = dec_instr_1.valid;
            wdata_even = dec_instr_1;
            wr_odd     = dec_instr_0.valid;
            wdata_odd  = dec_instr_0;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (!stall && !flush) begin
            if (wr_odd)
                odd_bank[tail_odd] <= wdata_odd;
            if (wr_even)
                even_bank[tail_even] <= wdata_even;
        end
    end

    // tails
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_even <= '0;
            tail_odd  <= '0;
        end else if (flush) begin
            tail_even <= '0;
            tail_odd  <= '0;
        end else if (!stall) begin
            if (wr_odd)
                tail_odd <= step(tail_odd);
            if (wr_even)
                tail_even <= step(tail_even);
        end
    end

    // drain also allowed on overflow while decode is held off
    assign advance  = !stall || (overflow && !stall_decode);
    assign pop_odd  = odd_first ? issue_old : issue_young;
    assign pop_even = odd_first ? issue_young : issue_old;

    // heads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_even <= '0;
            head_odd  <= '0;
        end else if (flush) begin
            head_even <= '0;
            head_odd  <= '0;
        end else if (advance) begin
            if (pop_odd)
                head_odd <= step(head_odd);
            if (pop_even)
                head_even <= step(head_even);
        end
    end

endmodule

`default_nettype wire

// ==== hw/issue_pkg.sv ====
`default_nettype none

`include "issue_settings.svh"

package issue_pkg;

    // decoded fields minus sources, plus operand values
    typedef struct packed {
        logic                     valid;
        logic [31:0]              pc;
        logic [31:0]              raw_instr;
        instr_pkg::opcode_e       op;
        logic [`REG_ADDR_W-1:0]   rdst;
        logic [`DATA_W-1:0]       imm;
        logic                     regwrite;
        logic                     branch;
        logic                     jump;
        logic                     hiwrite;
        logic                     lowrite;
        logic                     hitoreg;
        logic                     lotoreg;
        logic                     cp0write;
        logic                     cp0toreg;
        instr_pkg::cp0_kind_e     cp0_kind;
        logic [4:0]               cp0_addr;
        logic [`DATA_W-1:0]       rd1;
        logic [`DATA_W-1:0]       rd2;
        // younger slot sits in a delay slot
        logic                     is_slot;
    } issued_instr_t;

    // shares the single hi/lo multiply unit
    function automatic logic is_muldiv(input instr_pkg::opcode_e op);
        return op == instr_pkg::OP_MULT || op == instr_pkg::OP_MULTU ||
               op == instr_pkg::OP_DIV  || op == instr_pkg::OP_DIVU;
    endfunction

    // branch or jump, owns a delay slot
    function automatic logic is_control(input instr_pkg::decoded_instr_t instr);
        return instr.branch || instr.jump;
    endfunction

endpackage

`default_nettype wire

// ==== hw/instr_pkg.sv ====
`default_nettype none

`include "issue_settings.svh"

package instr_pkg;

    // operation kind from decode
    typedef enum logic [4:0] {
        OP_ALU, OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_MFC0, OP_MTC0, OP_BRANCH, OP_JUMP,
        OP_LOAD, OP_STORE, OP_SYSCALL, OP_ERET
    } opcode_e;

    // cp0 side effect of the instruction
    typedef enum logic [1:0] {
        CP0_NONE, CP0_EXCEPTION, CP0_ERET
    } cp0_kind_e;

    // one issue queue entry
    typedef struct packed {
        logic                     valid;
        logic [31:0]              pc;
        logic [31:0]              raw_instr;
        opcode_e                  op;
        logic [`REG_ADDR_W-1:0]   ra1;
        logic [`REG_ADDR_W-1:0]   ra2;
        logic [`REG_ADDR_W-1:0]   rdst;
        logic [`DATA_W-1:0]       imm;
        logic                     regwrite;
        logic                     branch;
        logic                     jump;
        logic                     hiwrite;
        logic                     lowrite;
        logic                     hitoreg;
        logic                     lotoreg;
        logic                     cp0write;
        logic                     cp0toreg;
        cp0_kind_e                cp0_kind;
        logic [4:0]               cp0_addr;
    } decoded_instr_t;

endpackage

`default_nettype wire

// ==== hw/issue_settings.svh ====
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// entries per bank, even and odd alike
`define ISSUE_QUEUE_DEPTH 16
// bank index width
`define ISSUE_INDEX_W 4

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// datapath width
`define DATA_W 32

`endif
